/* verilog.f */
+incdir+tests
verilog/cart_pkg.sv
verilog/cart_header_decode.sv
verilog/rom_mirror_calc.sv
verilog/rom_addr_map.sv
verilog/cart_loader_top.sv
tests/tb_cart_loader.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the cart loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -j 0 \
	--top-module tb_cart_loader -f verilog.f > "$LOG" 2>&1 \
	&& ./obj_dir/Vtb_cart_loader >> "$LOG" 2>&1 \
	|| echo "TB FAILED" >> "$LOG"

cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
	exit 1
fi
exit 0

/* tests/tb_cart_model.svh */
`ifndef TB_CART_MODEL_SVH
`define TB_CART_MODEL_SVH

// ========================================
// Random source
// ========================================

logic [31:0] lfsr_state = 32'h6061ee52;

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One LFSR step for every bit taken
function automatic logic [31:0] rand_bits(int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		v = {v[30:0], lfsr_state[0]};
	end
	return v;
endfunction

// ========================================
// Expected cartridge info
// ========================================

// Bytes minus one for a size code, kept to 24 bits
function automatic rom_addr_t size_mask(size_code_t code);
	return rom_addr_t'((33'd1 << (code + 10)) - 33'd1);
endfunction

function automatic cart_info_t exp_cart_info(hdr_mode_t mode, region_sel_t rsel, dl_word_t w0,
		logic region_bit, size_code_t hdr_rom, size_code_t hdr_ram);
	cart_info_t ci;
	size_code_t rom_code;
	size_code_t ram_code;
	rom_code = DEFAULT_ROM_SIZE;
	ram_code = 4'd0;
	// Auto mode packs both codes into the low byte
	if (mode == 3'd0 && w0[7:0] != 8'h00) begin
		rom_code = w0[3:0];
		ram_code = w0[7:4];
	end
	// Forced header modes read the internal header
	if (mode >= 3'd2 && mode <= 3'd4) begin
		rom_code = hdr_rom;
		ram_code = hdr_ram;
	end
	case (mode)
		3'd1, 3'd2: ci.rom_type = 8'd0;
		3'd3:       ci.rom_type = 8'd1;
		3'd4:       ci.rom_type = 8'd2;
		default:    ci.rom_type = w0[15:8];
	endcase
	ci.rom_mask = size_mask(rom_code);
	ci.ram_mask = (ram_code == 4'd0) ? 24'd0 : size_mask(ram_code);
	ci.ram_size = ram_code;
	ci.pal      = (rsel == 2'd0) ? region_bit : (rsel >= 2'd2);
	return ci;
endfunction

// ========================================
// Expected mapped address
// ========================================

function automatic rom_addr_t exp_map(rom_addr_t addr, rom_addr_t mask, logic en,
		rom_addr_t fsize);
	rom_addr_t split;
	rom_addr_t rmask;
	logic      found;
	split = MIN_MIRROR_SPLIT;
	found = 1'b0;
	// Top set bit among 23 down to 19
	for (int b = 23; b >= 19; b--) begin
		if (!found && fsize[b]) begin
			split    = '0;
			split[b] = 1'b1;
			found    = 1'b1;
		end
	end
	rmask = fsize - split - 24'd1;
	if (en && (addr & ~mask) == '0 && (addr & split) != '0)
		return split | (addr & rmask);
	return addr;
endfunction

`endif

/* tests/tb_cart_loader.sv */
`timescale 1ns/10ps

module tb_cart_loader
	import cart_pkg::*;
();

`include "tb_cart_model.svh"

localparam int RESET_CYCLES = 10;
localparam int FILLER_BEATS = 12;
localparam int N_DOWNLOADS  = 25;
localparam int DL_CYCLES    = 32;
localparam int N_REQUESTS   = 270;
localparam int STIM_CYCLES  = RESET_CYCLES + N_DOWNLOADS * DL_CYCLES + N_REQUESTS + 20;

logic        clk_sys = 1'b0;
logic        RESET;
logic        dl_active;
logic        rom_req;
hdr_mode_t   hdr_mode;
region_sel_t region_sel;
dl_beat_t    dl_beat;
rom_addr_t   rom_addr;
cart_info_t  info;
logic        map_valid;
rom_addr_t   map_addr;

// Expected state of the loaded cartridge
cart_info_t  cur_info;
logic        mirror_on;
rom_addr_t   cur_fsize;
logic        pal_hold;

string       test_name;
int          err_cnt = 0;
int          cycle_cnt = 0;
rom_addr_t   exp_addr_q[$];
int          exp_cycle_q[$];

cart_loader_top dut (
	.clk_sys    (clk_sys),
	.RESET      (RESET),
	.dl_active  (dl_active),
	.rom_req    (rom_req),
	.hdr_mode   (hdr_mode),
	.region_sel (region_sel),
	.dl_beat    (dl_beat),
	.rom_addr   (rom_addr),
	.info       (info),
	.map_valid  (map_valid),
	.map_addr   (map_addr)
);

always #2 clk_sys = ~clk_sys;

always @(posedge clk_sys)
	cycle_cnt <= cycle_cnt + 1;

// ========================================
// Error reporting
// ========================================

task automatic abort_run(input string msg);
	err_cnt++;
	$display("ERROR in test %s: %s", test_name, msg);
	$display("TB FAILED");
	$fatal(1, "stopped on first error");
endtask

task automatic report_mismatch(input string what, input logic [63:0] exp_v,
		input logic [63:0] act_v);
	err_cnt++;
	$display("MISMATCH test %s %s expected %0h actual %0h", test_name, what, exp_v, act_v);
	$display("TB FAILED");
	$fatal(1, "stopped on first error");
endtask

task automatic check_eq(input string what, input logic [63:0] exp_v, input logic [63:0] act_v);
	assert (act_v == exp_v) else report_mismatch(what, exp_v, act_v);
endtask

// ========================================
// Download stream
// ========================================

function automatic dl_addr_t size_word_addr(hdr_mode_t mode);
	case (mode)
		3'd2:    return LOROM_HDR_ADDR;
		3'd3:    return HIROM_HDR_ADDR;
		default: return EXHIROM_HDR_ADDR;
	endcase
endfunction

task automatic write_beat(input dl_addr_t addr, input dl_word_t data);
	dl_beat.wr   = 1'b1;
	dl_beat.addr = addr;
	dl_beat.data = data;
	@(posedge clk_sys);
	#1;
	dl_beat.wr = 1'b0;
	check_eq("pal during download", 64'(pal_hold), 64'(info.pal));
endtask

task automatic stream_cart(input hdr_mode_t mode, input region_sel_t rsel, input dl_word_t w0,
		input logic region_bit, input size_code_t hdr_rom, input size_code_t hdr_ram,
		input rom_addr_t fsize);
	dl_addr_t hdr_addr;
	hdr_mode   = mode;
	region_sel = rsel;
	dl_active  = 1'b1;
	pal_hold   = info.pal;
	write_beat(25'd0, w0);
	write_beat(25'd2, {7'd0, region_bit, 8'h00});
	write_beat(25'd8, fsize[15:0]);
	write_beat(25'd10, {8'h00, fsize[23:16]});
	for (int i = 0; i < FILLER_BEATS; i++)
		write_beat(25'h100 + dl_addr_t'(2 * i), dl_word_t'(rand_bits(16)));
	if (mode >= 3'd2 && mode <= 3'd4) begin
		hdr_addr = size_word_addr(mode);
		write_beat(hdr_addr, {4'h0, hdr_rom, 8'h00});
		write_beat(hdr_addr + 25'd2, {12'h000, hdr_ram});
	end
	dl_active = 1'b0;
	repeat (5) @(posedge clk_sys);
	#1;
endtask

task automatic load_and_check(input hdr_mode_t mode, input region_sel_t rsel,
		input dl_word_t w0, input logic region_bit, input size_code_t hdr_rom,
		input size_code_t hdr_ram, input rom_addr_t fsize);
	cart_info_t want;
	want = exp_cart_info(mode, rsel, w0, region_bit, hdr_rom, hdr_ram);
	stream_cart(mode, rsel, w0, region_bit, hdr_rom, hdr_ram, fsize);
	check_eq("rom_type", 64'(want.rom_type), 64'(info.rom_type));
	check_eq("rom_mask", 64'(want.rom_mask), 64'(info.rom_mask));
	check_eq("ram_mask", 64'(want.ram_mask), 64'(info.ram_mask));
	check_eq("ram_size", 64'(want.ram_size), 64'(info.ram_size));
	check_eq("pal", 64'(want.pal), 64'(info.pal));
	cur_info  = want;
	mirror_on = $countones(fsize) > 1;
	cur_fsize = fsize;
endtask

// ========================================
// ROM requests
// ========================================

task automatic send_request(input rom_addr_t a);
	rom_req  = 1'b1;
	rom_addr = a;
	exp_addr_q.push_back(exp_map(a, cur_info.rom_mask, mirror_on, cur_fsize));
	exp_cycle_q.push_back(cycle_cnt + 1);
	@(posedge clk_sys);
	#1;
endtask

task automatic finish_requests();
	rom_req = 1'b0;
	while (exp_addr_q.size() != 0)
		@(posedge clk_sys);
	#1;
endtask

// Result due one cycle after its request
always @(negedge clk_sys) begin : compare_results
	int        due;
	rom_addr_t want;
	if (!RESET) begin
		if (map_valid) begin
			assert (exp_addr_q.size() != 0) else abort_run("map_valid with no request pending");
			if (exp_addr_q.size() != 0) begin
				due  = exp_cycle_q.pop_front();
				want = exp_addr_q.pop_front();
				assert (due == cycle_cnt) else abort_run("map_valid on the wrong cycle");
				check_eq("map_addr", 64'(want), 64'(map_addr));
			end
		end else if (exp_cycle_q.size() != 0) begin
			assert (exp_cycle_q[0] > cycle_cnt) else abort_run("map_valid missing for a request");
		end
	end
end

initial begin : watchdog
	repeat (STIM_CYCLES * 2 + 1000) @(posedge clk_sys);
	$display("ERROR: timeout after %0d cycles, the run did not finish", STIM_CYCLES * 2 + 1000);
	$display("TB FAILED");
	$fatal(1, "watchdog expired");
end

// ========================================
// Test sequence
// ========================================

initial begin : main_seq
	dl_word_t  w0;
	rom_addr_t fs;
	logic      rb;
	RESET      = 1'b1;
	dl_active  = 1'b0;
	rom_req    = 1'b0;
	hdr_mode   = 3'd0;
	region_sel = 2'd0;
	dl_beat    = '0;
	rom_addr   = '0;
	cur_info   = '0;
	mirror_on  = 1'b0;
	cur_fsize  = '0;
	pal_hold   = 1'b0;
	test_name  = "reset";
	repeat (RESET_CYCLES) @(posedge clk_sys);
	#1;
	RESET = 1'b0;
	check_eq("info", 64'd0, 64'(info));
	check_eq("map_valid", 64'd0, 64'(map_valid));

	test_name = "auto_header";
	for (int i = 0; i < 8; i++) begin
		w0 = dl_word_t'(rand_bits(16));
		// Zero low byte falls back to the default size
		if (i % 4 == 3)
			w0[7:0] = 8'h00;
		rb = 1'(rand_bits(1));
		load_and_check(3'd0, 2'd0, w0, rb, 4'd0, 4'd0, 24'h200000);
	end

	test_name = "forced_modes";
	for (int m = 1; m <= 4; m++) begin
		w0 = dl_word_t'(rand_bits(16)) | 16'h0011;
		load_and_check(hdr_mode_t'(m), 2'd1, w0, 1'b0, size_code_t'(rand_bits(4)),
			size_code_t'(rand_bits(4)), 24'h200000);
	end

	test_name = "region";
	for (int i = 0; i < 6; i++) begin
		// Header bit opposite to each forced region
		rb = (i == 0) || (i % 4 == 1);
		load_and_check(3'd1, region_sel_t'(i % 4), 16'h0000, rb, 4'd0, 4'd0, 24'h200000);
	end

	test_name = "mirror_map";
	for (int f = 0; f < 4; f++) begin
		fs = rom_addr_t'(rand_bits(22)) | 24'h080001;
		load_and_check(3'd1, 2'd1, 16'h0000, 1'b0, 4'd0, 4'd0, fs);
		for (int k = 0; k < 50; k++)
			send_request(rom_addr_t'(rand_bits(22)));
		finish_requests();
	end

	test_name = "passthrough";
	load_and_check(3'd1, 2'd1, 16'h0000, 1'b0, 4'd0, 4'd0, 24'h300000);
	for (int k = 0; k < 10; k++)
		send_request(rom_addr_t'(rand_bits(22)));
	finish_requests();
	// Power-of-two file must drop the earlier mirroring
	load_and_check(3'd1, 2'd1, 16'h0000, 1'b0, 4'd0, 4'd0, 24'h200000);
	for (int k = 0; k < 30; k++)
		send_request(rom_addr_t'(rand_bits(22)));
	finish_requests();
	load_and_check(3'd1, 2'd1, 16'h0000, 1'b0, 4'd0, 4'd0, 24'h280000);
	for (int k = 0; k < 30; k++)
		send_request(rom_addr_t'(rand_bits(24)) | 24'h400000);
	finish_requests();

	if (err_cnt == 0) begin
		$display("TB PASSED");
	end else begin
		$display("TB FAILED");
	end
	$finish;
end

endmodule

/* verilog/cart_loader_top.sv */
`timescale 1ns/10ps

module cart_loader_top
	import cart_pkg::*;
(
	input  logic        clk_sys,
	input  logic        RESET,
	input  logic        dl_active,
	input  logic        rom_req,
	input  hdr_mode_t   hdr_mode,
	input  region_sel_t region_sel,
	input  dl_beat_t    dl_beat,
	input  rom_addr_t   rom_addr,
	output cart_info_t  info,
	output logic        map_valid,
	output rom_addr_t   map_addr
);

// Between decode and mirror stages
rom_addr_t   file_size;
logic        dl_start;
logic        dl_done;

// Between mirror and address stages
mirror_cfg_t mirror;

// ========================================
// Header parse
// ========================================

cart_header_decode header_decode (
	.clk_sys    (clk_sys),
	.RESET      (RESET),
	.hdr_mode   (hdr_mode),
	.region_sel (region_sel),
	.dl_active  (dl_active),
	.dl_beat    (dl_beat),
	.info       (info),
	.file_size  (file_size),
	.dl_start   (dl_start),
	.dl_done    (dl_done)
);

// Mirror setup at end of download
rom_mirror_calc mirror_calc (
	.clk_sys   (clk_sys),
	.RESET     (RESET),
	.dl_start  (dl_start),
	.dl_done   (dl_done),
	.file_size (file_size),
	.mirror    (mirror)
);

// ========================================
// Address path
// ========================================

rom_addr_map addr_map (
	.clk_sys   (clk_sys),
	.RESET     (RESET),
	.rom_req   (rom_req),
	.rom_addr  (rom_addr),
	.rom_mask  (info.rom_mask),
	.mirror    (mirror),
	.map_valid (map_valid),
	.map_addr  (map_addr)
);

endmodule

/* verilog/rom_addr_map.sv */
`timescale 1ns/10ps

module rom_addr_map
	import cart_pkg::*;
(
	input  logic        clk_sys,
	input  logic        RESET,
	input  logic        rom_req,
	input  rom_addr_t   rom_addr,
	input  rom_addr_t   rom_mask,
	input  mirror_cfg_t mirror,
	output logic        map_valid,
	output rom_addr_t   map_addr
);

logic      in_range;
logic      in_mirror;
rom_addr_t addr_nxt;

// ========================================
// Translation
// ========================================

// Nothing set above the ROM size
assign in_range = ~|(rom_addr & ~rom_mask);

// Upper half of a short image folds onto its tail
assign in_mirror = mirror.en & in_range & (|(rom_addr & mirror.split));

assign addr_nxt = in_mirror ? (mirror.split | (rom_addr & mirror.rmask)) : rom_addr;

// ========================================
// Output stage
// ========================================

always_ff @(posedge clk_sys) begin
	if (RESET)
		map_valid <= 1'b0;
	else
		map_valid <= rom_req;
end

// One result per request, back to back
always_ff @(posedge clk_sys) begin
	if (rom_req)
		map_addr <= addr_nxt;
end

endmodule

/* verilog/rom_mirror_calc.sv */
`timescale 1ns/10ps

module rom_mirror_calc
	import cart_pkg::*;
(
	input  logic        clk_sys,
	input  logic        RESET,
	input  logic        dl_start,
	input  logic        dl_done,
	input  rom_addr_t   file_size,
	output mirror_cfg_t mirror
);

// Registered configuration
logic      mirror_en;
rom_addr_t mirror_split;
rom_addr_t mirror_rmask;

// Next configuration from the file size
logic      size_npot;
rom_addr_t split_nxt;
rom_addr_t rmask_nxt;

// ========================================
// Split search
// ========================================

// Any second set bit means not a power of two
assign size_npot = |(file_size & (file_size - rom_addr_t'(1)));

// Highest set bit in 23..19, later iterations win
always_comb begin
	split_nxt = MIN_MIRROR_SPLIT;
	for (int b = 19; b <= 23; b++) begin
		if (file_size[b])
			split_nxt = rom_addr_t'(1) << b;
	end
end

// Size of the tail above the split
assign rmask_nxt = file_size - split_nxt - rom_addr_t'(1);

// ========================================
// Configuration registers
// ========================================

always_ff @(posedge clk_sys) begin
	if (RESET) begin
		mirror_en <= 1'b0;
	end else begin
		if (dl_start)
			mirror_en <= 1'b0;
		// Power-of-two files keep mirroring off
		if (dl_done && size_npot)
			mirror_en <= 1'b1;
	end
end

always_ff @(posedge clk_sys) begin
	if (dl_done && size_npot) begin
		mirror_split <= split_nxt;
		mirror_rmask <= rmask_nxt;
	end
end

assign mirror = '{
	en:    mirror_en,
	split: mirror_split,
	rmask: mirror_rmask
};

endmodule

/* verilog/cart_header_decode.sv */
`timescale 1ns/10ps

module cart_header_decode
	import cart_pkg::*;
(
	input  logic        clk_sys,
	input  logic        RESET,
	input  hdr_mode_t   hdr_mode,
	input  region_sel_t region_sel,
	input  logic        dl_active,
	input  dl_beat_t    dl_beat,
	output cart_info_t  info,
	output rom_addr_t   file_size,
	output logic        dl_start,
	output logic        dl_done
);

// Header fields
size_code_t rom_size;
size_code_t ram_size;
logic [7:0] rom_type;
logic       hdr_region;
logic       pal;
logic       info_vld;

// Download edge tracking
logic       dl_active_q;

// Size word location in the forced modes
logic       hdr_fixed;
dl_addr_t   size_addr;
logic       wr_en;

rom_addr_t  rom_mask;
rom_addr_t  ram_mask;

// Byte count minus one for a size code
function automatic rom_addr_t code_mask(size_code_t code);
	return (rom_addr_t'(1024) << code) - rom_addr_t'(1);
endfunction

assign wr_en = dl_active & dl_beat.wr;

always_comb begin
	hdr_fixed = 1'b1;
	case (hdr_mode)
		3'd2: size_addr = LOROM_HDR_ADDR;
		3'd3: size_addr = HIROM_HDR_ADDR;
		3'd4: size_addr = EXHIROM_HDR_ADDR;
		default: begin
			// Auto and no-header take sizes from word 0
			size_addr = '0;
			hdr_fixed = 1'b0;
		end
	endcase
end

// ========================================
// Header capture
// ========================================

always_ff @(posedge clk_sys) begin
	if (RESET) begin
		rom_size    <= '0;
		ram_size    <= '0;
		rom_type    <= '0;
		hdr_region  <= 1'b0;
		info_vld    <= 1'b0;
		pal         <= 1'b0;
		dl_active_q <= 1'b0;
		dl_start    <= 1'b0;
		dl_done     <= 1'b0;
	end else begin
		dl_active_q <= dl_active;
		dl_start    <= dl_active & ~dl_active_q;
		dl_done     <= dl_active_q & ~dl_active;

		if (wr_en) begin
			if (dl_beat.addr == '0) begin
				info_vld <= 1'b1;
				rom_size <= DEFAULT_ROM_SIZE;
				ram_size <= '0;
				// Packed size byte from the loader in auto mode
				if (hdr_mode == 3'd0 && dl_beat.data[7:0] != 8'h00) begin
					ram_size <= dl_beat.data[7:4];
					rom_size <= dl_beat.data[3:0];
				end
				case (hdr_mode)
					3'd1, 3'd2: rom_type <= 8'd0;
					3'd3:       rom_type <= 8'd1;
					3'd4:       rom_type <= 8'd2;
					default:    rom_type <= dl_beat.data[15:8];
				endcase
			end

			if (dl_beat.addr == dl_addr_t'(2))
				hdr_region <= dl_beat.data[8];

			if (hdr_fixed && dl_beat.addr == size_addr)
				rom_size <= dl_beat.data[11:8];
			if (hdr_fixed && dl_beat.addr == size_addr + dl_addr_t'(2))
				ram_size <= dl_beat.data[3:0];
		end

		// Region held steady while a file streams in
		if (!dl_active)
			pal <= (region_sel == 2'd0) ? hdr_region : region_sel[1];
	end
end

// File size words from the loader preamble
always_ff @(posedge clk_sys) begin
	if (wr_en) begin
		if (dl_beat.addr == dl_addr_t'(8))
			file_size[15:0] <= dl_beat.data;
		if (dl_beat.addr == dl_addr_t'(10))
			file_size[23:16] <= dl_beat.data[7:0];
	end
end

// ========================================
// Outputs
// ========================================

assign rom_mask = info_vld ? code_mask(rom_size) : '0;
assign ram_mask = (ram_size == '0) ? '0 : code_mask(ram_size);

assign info = '{
	rom_type: rom_type,
	rom_mask: rom_mask,
	ram_mask: ram_mask,
	ram_size: ram_size,
	pal:      pal
};

endmodule

/* verilog/cart_pkg.sv */
package cart_pkg;

// ========================================
// Width types
// ========================================

// Console ROM address or stored image byte address
typedef logic [23:0] rom_addr_t;

// Byte address inside the downloaded file
typedef logic [24:0] dl_addr_t;

// One loader data word
typedef logic [15:0] dl_word_t;

// Size code where bytes = 1024 << code
typedef logic [3:0] size_code_t;

// 0 auto, 1 none, 2 LoROM, 3 HiROM, 4 ExHiROM
typedef logic [2:0] hdr_mode_t;

// 0 auto, 1 NTSC, 2 and 3 PAL
typedef logic [1:0] region_sel_t;

// ========================================
// Bundles
// ========================================

// Single loader write
typedef struct packed {
	logic     wr;
	dl_addr_t addr;
	dl_word_t data;
} dl_beat_t;

// Decoded cartridge description
typedef struct packed {
	logic [7:0] rom_type;
	rom_addr_t  rom_mask;
	rom_addr_t  ram_mask;
	size_code_t ram_size;
	logic       pal;
} cart_info_t;

// Mirroring for images whose size is not a power of two
typedef struct packed {
	logic      en;
	rom_addr_t split;
	rom_addr_t rmask;
} mirror_cfg_t;

// ========================================
// Header layout
// ========================================

// Copier header in front of the image
localparam dl_addr_t COPIER_HDR_BYTES = 25'd512;

// File address of the size word, RAM size word sits 2 bytes higher
localparam dl_addr_t LOROM_HDR_ADDR   = 25'h007FD6 + COPIER_HDR_BYTES;
localparam dl_addr_t HIROM_HDR_ADDR   = 25'h00FFD6 + COPIER_HDR_BYTES;
localparam dl_addr_t EXHIROM_HDR_ADDR = 25'h40FFD6 + COPIER_HDR_BYTES;

// 4 MiB when the header gives nothing better
localparam size_code_t DEFAULT_ROM_SIZE = 4'd12;

// Smallest split used by the mirror logic
localparam rom_addr_t MIN_MIRROR_SPLIT = 24'h040000;

endpackage
